// ==== rtl/uart_pkg.sv ====
package uart_pkg;

    // Clock cycles per quarter-bit sample tick.
    localparam int unsigned CLKS_PER_SAMPLE = 4;
    // Sample ticks per bit, so one bit is 16 cycles.
    localparam int unsigned SAMPLES_PER_BIT = 4;
    localparam int unsigned CYC_W = $clog2(CLKS_PER_SAMPLE);
    localparam int unsigned PHASE_W = $clog2(SAMPLES_PER_BIT);

    // Start, eight data bits, stop.
    localparam int unsigned FRAME_BITS = 10;
    localparam int unsigned BIT_CNT_W = 4;

    // FIFO depths, powers of two.
    localparam int unsigned TX_DEPTH = 4;
    localparam int unsigned RX_DEPTH = 4;

    // Word addresses, selected by byte address bit 2.
    localparam logic ADDR_DATA = 1'b0;
    localparam logic ADDR_STATUS = 1'b1;

    // Receiver FSM states.
    localparam logic [1:0] RX_IDLE = 2'd0;
    localparam logic [1:0] RX_DATA = 2'd1;
    localparam logic [1:0] RX_WAIT = 2'd2;

    // Bus read word, seen as received data or as status.
    typedef union packed {
        struct packed {
            // Set when a byte was popped.
            logic        rx_valid;
            logic [22:0] pad;
            logic [7:0]  rx_byte;
        } data;
        struct packed {
            logic [11:0] pad_hi;
            // Sticky stop bit error.
            logic        frame_err;
            logic        rx_full;
            logic        rx_nonempty;
            logic        rx_busy;
            logic [12:0] pad_lo;
            logic        tx_full;
            logic        tx_nonempty;
            logic        tx_busy;
        } status;
    } uart_rdata_t;

endpackage

// ==== rtl/uart_baud_gen.sv ====
`timescale 1ns/1ps

module uart_baud_gen
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic sample_tick,
    output logic bit_tick
);

    // Cycles within one quarter-bit.
    logic [CYC_W-1:0] cyc_cnt;
    // Quarter-bits within one bit.
    logic [PHASE_W-1:0] qtr_cnt;

    // Last cycle of each quarter-bit.
    assign sample_tick = (cyc_cnt == CYC_W'(CLKS_PER_SAMPLE - 1));
    // Last quarter of each bit.
    assign bit_tick = sample_tick && (qtr_cnt == PHASE_W'(SAMPLES_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_cnt <= '0;
            qtr_cnt <= '0;
        end else begin
            // Both counters wrap naturally at powers of two.
            cyc_cnt <= cyc_cnt + 1'b1;
            if (sample_tick) begin
                qtr_cnt <= qtr_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo #(
    parameter int depth = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       empty,
    output logic       full
);

    // Byte storage.
    logic [7:0] mem [depth];

    // Pointers carry one extra wrap bit.
    logic [$clog2(depth):0] wr_ptr;
    logic [$clog2(depth):0] rd_ptr;
    logic [$clog2(depth):0] wr_next;
    logic [$clog2(depth):0] rd_next;
    // Entries held, from the pointer distance.
    logic [$clog2(depth):0] count;

    logic push_ok;
    logic pop_ok;

    // Requests against a full or empty FIFO are dropped.
    assign push_ok = push && !full;
    assign pop_ok = pop && !empty;

    assign count = wr_ptr - rd_ptr;

    always_comb begin
        wr_next = wr_ptr;
        rd_next = rd_ptr;
        if (push_ok) begin
            wr_next = wr_ptr + 1'b1;
        end
        if (pop_ok) begin
            rd_next = rd_ptr + 1'b1;
        end
    end

    // Head of queue read combinationally.
    assign pop_data = mem[rd_ptr[$clog2(depth)-1:0]];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr[$clog2(depth)-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            wr_ptr <= wr_next;
            rd_ptr <= rd_next;
            // Flags come from the next pointers.
            empty  <= (wr_next == rd_next);
            // Full when only the wrap bit differs.
            full   <= ((wr_next ^ rd_next) == {1'b1, {$clog2(depth){1'b0}}});
        end
    end

    // Occupancy never exceeds the slots.
    // A push taken on full or a pop taken on empty would break it.
    assert property (@(posedge clk) disable iff (rst)
        count <= ($clog2(depth) + 1)'(depth));

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       bit_tick,
    input  logic       fifo_empty,
    input  logic [7:0] fifo_data,
    output logic       fifo_pop,
    output logic       txd,
    output logic       busy
);

    // Shift register whose LSB drives the line.
    logic [FRAME_BITS-1:0] frame;
    // Bits already finished in this frame.
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic last_bit;

    // Stop bit is on the line.
    assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // Load when idle or right as the stop bit ends.
    assign fifo_pop = bit_tick && !fifo_empty && (!busy || last_bit);

    assign txd = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            frame   <= '1;
            bit_cnt <= '0;
            busy    <= 1'b0;
        end else if (fifo_pop) begin
            // Stop, data, start.
            frame   <= {1'b1, fifo_data, 1'b0};
            bit_cnt <= '0;
            busy    <= 1'b1;
        end else if (bit_tick && busy) begin
            // Ones fill in behind the frame.
            frame <= {1'b1, frame[FRAME_BITS-1:1]};
            if (last_bit) begin
                bit_cnt <= '0;
                busy    <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Idle line is high.
    assert property (@(posedge clk) disable iff (rst)
        !busy |-> txd);

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sample_tick,
    input  logic       rxd,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       busy,
    output logic       frame_err
);

    // Two-stage synchronizer.
    logic rxd_meta;
    logic rxd_sync;

    logic [1:0] state;
    // Free-running quarter phase.
    logic [PHASE_W-1:0] phase;
    // Phase at which bits are sampled, mid-bit.
    logic [PHASE_W-1:0] samp_phase;
    logic [BIT_CNT_W-1:0] bit_cnt;
    // Data bits arrive LSB first.
    logic [7:0] shreg;
    logic samp_now;

    assign busy = (state != RX_IDLE);
    assign samp_now = sample_tick && (phase == samp_phase);

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RX_IDLE;
            phase      <= '0;
            samp_phase <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            if (sample_tick) begin
                phase <= phase + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    // Start edge found, sample half a bit later.
                    if (sample_tick && !rxd_sync) begin
                        state      <= RX_DATA;
                        samp_phase <= phase + PHASE_W'(SAMPLES_PER_BIT / 2);
                        bit_cnt    <= '0;
                    end
                end
                RX_DATA: begin
                    if (samp_now) begin
                        if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
                            // Mid stop bit.
                            if (rxd_sync) begin
                                byte_valid <= 1'b1;
                                state      <= RX_IDLE;
                            end else begin
                                frame_err <= 1'b1;
                                state     <= RX_WAIT;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_WAIT: begin
                    // Line must go high again first.
                    if (samp_now && rxd_sync) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Payload path, no reset.
    always_ff @(posedge clk) begin
        // Start bit sample is skipped.
        if (state == RX_DATA && samp_now && bit_cnt != '0
                && bit_cnt != BIT_CNT_W'(FRAME_BITS - 1)) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
        if (state == RX_DATA && samp_now && bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
            byte_data <= shreg;
        end
    end

    // One strobe per good frame.
    assert property (@(posedge clk) disable iff (rst)
        byte_valid |=> !byte_valid);

endmodule

// ==== rtl/uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  bus_addr,
    input  logic        bus_we,
    input  logic        bus_re,
    input  logic [31:0] bus_wdata,
    output uart_rdata_t bus_rdata,
    output logic        bus_ready,
    output logic        tx_push,
    output logic [7:0]  tx_push_data,
    input  logic        tx_full,
    input  logic        tx_empty,
    input  logic        tx_busy,
    output logic        rx_pop,
    input  logic [7:0]  rx_data,
    input  logic        rx_empty,
    input  logic        rx_full,
    input  logic        rx_busy,
    input  logic        frame_err_pulse
);

    logic sel_data;
    logic sel_status;
    logic stall;
    // Sticky framing error.
    logic frame_err;
    uart_rdata_t rd_word;

    assign sel_data = (bus_addr[2] == ADDR_DATA);
    assign sel_status = (bus_addr[2] == ADDR_STATUS);

    // Data write against a full transmit FIFO.
    assign stall = bus_we && sel_data && tx_full;

    assign tx_push = bus_we && sel_data && !tx_full;
    assign tx_push_data = bus_wdata[7:0];
    assign rx_pop = bus_re && sel_data && !rx_empty;

    always_comb begin
        rd_word = '0;
        if (sel_status) begin
            rd_word.status.tx_busy     = tx_busy;
            rd_word.status.tx_nonempty = !tx_empty;
            rd_word.status.tx_full     = tx_full;
            rd_word.status.rx_busy     = rx_busy;
            rd_word.status.rx_nonempty = !rx_empty;
            rd_word.status.rx_full     = rx_full;
            rd_word.status.frame_err   = frame_err;
        end else begin
            // Head byte is valid only if something is there.
            rd_word.data.rx_byte  = rx_data;
            rd_word.data.rx_valid = !rx_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_ready <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            bus_ready <= !stall;
            // A new error wins over the clear.
            if (frame_err_pulse) begin
                frame_err <= 1'b1;
            end else if (bus_re && sel_status) begin
                frame_err <= 1'b0;
            end
        end
    end

    // Response word loaded on every read.
    always_ff @(posedge clk) begin
        if (bus_re) begin
            bus_rdata <= rd_word;
        end
    end

    // Master issues one request at a time.
    assert property (@(posedge clk) disable iff (rst)
        !(bus_we && bus_re));

endmodule

// ==== rtl/uart_periph.sv ====
`timescale 1ns/1ps

module uart_periph
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  bus_addr,
    input  logic        bus_we,
    input  logic        bus_re,
    input  logic [31:0] bus_wdata,
    output uart_rdata_t bus_rdata,
    output logic        bus_ready,
    output logic        txd,
    input  logic        rxd,
    output logic        tx_empty,
    output logic        rx_avail
);

    logic       sample_tick;
    logic       bit_tick;

    // Transmit path.
    logic       tx_push;
    logic [7:0] tx_push_data;
    logic       tx_pop;
    logic [7:0] tx_head;
    logic       tx_fifo_empty;
    logic       tx_fifo_full;
    logic       tx_busy;

    // Receive path.
    logic       rx_byte_valid;
    logic [7:0] rx_byte;
    logic       rx_pop;
    logic [7:0] rx_head;
    logic       rx_fifo_empty;
    logic       rx_fifo_full;
    logic       rx_busy;
    logic       frame_err_pulse;

    // Interrupt levels.
    assign tx_empty = tx_fifo_empty && !tx_busy;
    assign rx_avail = !rx_fifo_empty;

    uart_baud_gen u_baud_gen (
        .clk(clk), .rst(rst), .sample_tick(sample_tick), .bit_tick(bit_tick)
    );

    uart_fifo #(.depth(TX_DEPTH)) u_tx_fifo (
        .clk(clk), .rst(rst), .push(tx_push), .push_data(tx_push_data),
        .pop(tx_pop), .pop_data(tx_head), .empty(tx_fifo_empty), .full(tx_fifo_full)
    );

    uart_tx u_tx (
        .clk(clk), .rst(rst), .bit_tick(bit_tick), .fifo_empty(tx_fifo_empty),
        .fifo_data(tx_head), .fifo_pop(tx_pop), .txd(txd), .busy(tx_busy)
    );

    uart_rx u_rx (
        .clk(clk), .rst(rst), .sample_tick(sample_tick), .rxd(rxd),
        .byte_valid(rx_byte_valid), .byte_data(rx_byte), .busy(rx_busy),
        .frame_err(frame_err_pulse)
    );

    // Bytes arriving while full are dropped by the FIFO.
    uart_fifo #(.depth(RX_DEPTH)) u_rx_fifo (
        .clk(clk), .rst(rst), .push(rx_byte_valid), .push_data(rx_byte),
        .pop(rx_pop), .pop_data(rx_head), .empty(rx_fifo_empty), .full(rx_fifo_full)
    );

    uart_regs u_regs (
        .clk(clk), .rst(rst), .bus_addr(bus_addr), .bus_we(bus_we), .bus_re(bus_re),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_ready(bus_ready),
        .tx_push(tx_push), .tx_push_data(tx_push_data), .tx_full(tx_fifo_full),
        .tx_empty(tx_fifo_empty), .tx_busy(tx_busy), .rx_pop(rx_pop),
        .rx_data(rx_head), .rx_empty(rx_fifo_empty), .rx_full(rx_fifo_full),
        .rx_busy(rx_busy), .frame_err_pulse(frame_err_pulse)
    );

endmodule

// ==== test/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

    // One bit on the line in clk cycles.
    localparam int BIT_CYCLES = CLKS_PER_SAMPLE * SAMPLES_PER_BIT;
    localparam int NUM_TESTS = 8;
    localparam int BURST_LEN = TX_DEPTH + 2;
    // Table frames plus the stall and overflow bursts.
    localparam int NUM_FRAMES = NUM_TESTS + 2 * BURST_LEN;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 12 * BIT_CYCLES + 2000;
    localparam int WAIT_LIMIT = 12 * BIT_CYCLES;
    localparam logic [3:0] DATA_ADDR = {1'b0, ADDR_DATA, 2'b00};
    localparam logic [3:0] STATUS_ADDR = {1'b0, ADDR_STATUS, 2'b00};
    // Table modes.
    localparam int MODE_LOOP = 0;
    localparam int MODE_GOOD = 1;
    localparam int MODE_BAD = 2;
    // Line conditions to wait for.
    localparam int SEL_TXD_LOW = 0;
    localparam int SEL_RX_AVAIL = 1;
    localparam int SEL_TX_EMPTY = 2;

    logic        clk;
    logic        rst;
    logic [3:0]  bus_addr;
    logic        bus_we;
    logic        bus_re;
    logic [31:0] bus_wdata;
    uart_rdata_t bus_rdata;
    logic        bus_ready;
    logic        txd;
    logic        rxd;
    logic        tx_empty;
    logic        rx_avail;
    // Loopback select and the directly driven line.
    logic        loopback;
    logic        line_rxd;

    int     errors;
    int     checks;
    integer seed;

    // Stimulus table.
    string      test_name [NUM_TESTS];
    int         test_mode [NUM_TESTS];
    logic [7:0] test_byte [NUM_TESTS];
    logic       exp_valid [NUM_TESTS];
    logic       exp_ferr [NUM_TESTS];
    logic [7:0] burst [BURST_LEN];

    assign rxd = loopback ? txd : line_rxd;

    uart_periph u_uart_periph (
        .clk(clk), .rst(rst), .bus_addr(bus_addr), .bus_we(bus_we), .bus_re(bus_re),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_ready(bus_ready),
        .txd(txd), .rxd(rxd), .tx_empty(tx_empty), .rx_avail(rx_avail)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic uart_rdata_t make_data(input logic valid, input logic [7:0] value);
        uart_rdata_t w;
        w = '0;
        w.data.rx_valid = valid;
        w.data.rx_byte = value;
        return w;
    endfunction

    function automatic uart_rdata_t make_status(
        input logic tx_busy,
        input logic tx_nonempty,
        input logic tx_full,
        input logic rx_busy,
        input logic rx_nonempty,
        input logic rx_full,
        input logic frame_err
    );
        uart_rdata_t w;
        w = '0;
        w.status.tx_busy = tx_busy;
        w.status.tx_nonempty = tx_nonempty;
        w.status.tx_full = tx_full;
        w.status.rx_busy = rx_busy;
        w.status.rx_nonempty = rx_nonempty;
        w.status.rx_full = rx_full;
        w.status.frame_err = frame_err;
        return w;
    endfunction

    function automatic logic condition_met(input int sel);
        case (sel)
            SEL_TXD_LOW:  return !txd;
            SEL_RX_AVAIL: return rx_avail;
            default:      return tx_empty;
        endcase
    endfunction

    task automatic check_data(input string name, input uart_rdata_t expected,
                              input uart_rdata_t actual);
        logic ok;
        ok = (actual.data.rx_valid === expected.data.rx_valid)
            && (actual.data.pad === expected.data.pad);
        // Byte field only counts when a byte was popped.
        if (expected.data.rx_valid) begin
            ok = ok && (actual.data.rx_byte === expected.data.rx_byte);
        end
        checks++;
        if (!ok) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name, input uart_rdata_t expected,
                                input uart_rdata_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Polls a line condition once per cycle.
    task automatic wait_until(input string what, input int sel, input int limit);
        int n;
        n = 0;
        while (!condition_met(sel) && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!condition_met(sel)) begin
            errors++;
            $display("Gave up waiting for %s after %0d cycles", what, limit);
        end
    endtask

    // Tasks start and end 1 ns after a rising edge.
    task automatic bus_write(input logic [7:0] value, output logic ready);
        bus_addr  = DATA_ADDR;
        bus_wdata = {24'h0, value};
        bus_we    = 1'b1;
        @(posedge clk);
        #1;
        bus_we = 1'b0;
        ready  = bus_ready;
    endtask

    // Repeats a stalled strobe until it is taken.
    task automatic write_retry(input string name, input logic [7:0] value);
        logic ready;
        int tries;
        tries = 0;
        bus_write(value, ready);
        while (!ready && tries < WAIT_LIMIT) begin
            bus_write(value, ready);
            tries++;
        end
        if (!ready) begin
            errors++;
            $display("%s: the write was never accepted", name);
        end
    endtask

    task automatic bus_read(input logic [3:0] addr, output uart_rdata_t word);
        bus_addr = addr;
        bus_re   = 1'b1;
        @(posedge clk);
        #1;
        bus_re = 1'b0;
        word   = bus_rdata;
        check_bit($sformatf("read ready at %h", addr), 1'b1, bus_ready);
    endtask

    // Status polling until the receiver is idle.
    task automatic wait_rx_idle(output uart_rdata_t word);
        int n;
        n = 0;
        bus_read(STATUS_ADDR, word);
        while (word.status.rx_busy && n < WAIT_LIMIT) begin
            bus_read(STATUS_ADDR, word);
            n++;
        end
        if (word.status.rx_busy) begin
            errors++;
            $display("Receiver stayed busy for %0d status reads", WAIT_LIMIT);
        end
    endtask

    // Start, data LSB first, given stop bit, then idle line.
    task automatic drive_frame(input logic [7:0] value, input logic stop);
        logic [9:0] bits;
        int i;
        bits = {stop, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            line_rxd = bits[i];
            repeat (BIT_CYCLES) @(posedge clk);
            #1;
        end
        // Two idle bits let a broken frame recover.
        line_rxd = 1'b1;
        repeat (2 * BIT_CYCLES) @(posedge clk);
        #1;
    endtask

    // Mid-bit samples of one 8N1 frame on txd.
    task automatic check_tx_frame(input string name, input logic [7:0] value);
        logic [9:0] bits;
        int i;
        bits = {1'b1, value, 1'b0};
        wait_until({name, " start edge"}, SEL_TXD_LOW, WAIT_LIMIT);
        repeat (BIT_CYCLES / 2) @(posedge clk);
        #1;
        for (i = 0; i < 10; i++) begin
            check_bit($sformatf("%s txd bit %0d", name, i), bits[i], txd);
            if (i < 9) begin
                repeat (BIT_CYCLES) @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic set_entry(input int idx, input string name, input int mode);
        test_name[idx] = name;
        test_mode[idx] = mode;
        test_byte[idx] = 8'($random(seed));
        // A low stop bit leaves nothing to read and sets the flag.
        exp_valid[idx] = (mode != MODE_BAD);
        exp_ferr[idx]  = (mode == MODE_BAD);
    endtask

    task automatic run_entry(input int idx);
        uart_rdata_t word;
        logic ready;
        string name;
        name = test_name[idx];
        if (test_mode[idx] == MODE_LOOP) begin
            loopback = 1'b1;
            bus_write(test_byte[idx], ready);
            check_bit({name, " ready"}, 1'b1, ready);
            check_tx_frame(name, test_byte[idx]);
        end else begin
            loopback = 1'b0;
            drive_frame(test_byte[idx], test_mode[idx] == MODE_GOOD);
        end
        if (exp_valid[idx]) begin
            wait_until({name, " rx_avail"}, SEL_RX_AVAIL, WAIT_LIMIT);
        end
        bus_read(DATA_ADDR, word);
        check_data({name, " data"}, make_data(exp_valid[idx], test_byte[idx]), word);
        if (exp_ferr[idx]) begin
            // Set on the first status read, cleared by it.
            bus_read(STATUS_ADDR, word);
            check_status({name, " flag set"},
                make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1), word);
            bus_read(STATUS_ADDR, word);
            check_status({name, " flag clear"},
                make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), word);
        end
    endtask

    task automatic stall_test();
        uart_rdata_t word;
        logic ready;
        int i;
        loopback = 1'b1;
        for (i = 0; i < BURST_LEN; i++) begin
            burst[i] = 8'($random(seed));
        end
        // First byte sits in the serializer for a whole frame.
        bus_write(burst[0], ready);
        check_bit("stall first ready", 1'b1, ready);
        wait_until("stall start edge", SEL_TXD_LOW, WAIT_LIMIT);
        for (i = 1; i <= TX_DEPTH; i++) begin
            bus_write(burst[i], ready);
            check_bit($sformatf("stall write %0d ready", i), 1'b1, ready);
        end
        bus_write(burst[BURST_LEN-1], ready);
        check_bit("stall full ready", 1'b0, ready);
        bus_read(STATUS_ADDR, word);
        check_status("stall status",
            make_status(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0), word);
        write_retry("stall retry", burst[BURST_LEN-1]);
        for (i = 0; i < BURST_LEN; i++) begin
            wait_until("stall rx_avail", SEL_RX_AVAIL, WAIT_LIMIT);
            bus_read(DATA_ADDR, word);
            check_data($sformatf("stall byte %0d", i), make_data(1'b1, burst[i]), word);
        end
    endtask

    task automatic overflow_test();
        uart_rdata_t word;
        int i;
        loopback = 1'b1;
        for (i = 0; i < BURST_LEN; i++) begin
            burst[i] = 8'($random(seed));
        end
        for (i = 0; i < BURST_LEN; i++) begin
            write_retry($sformatf("overflow write %0d", i), burst[i]);
        end
        wait_until("overflow tx_empty", SEL_TX_EMPTY, BURST_LEN * WAIT_LIMIT);
        wait_rx_idle(word);
        check_status("overflow status",
            make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0), word);
        // Oldest bytes kept, later ones dropped.
        for (i = 0; i < RX_DEPTH; i++) begin
            bus_read(DATA_ADDR, word);
            check_data($sformatf("overflow byte %0d", i), make_data(1'b1, burst[i]), word);
        end
        bus_read(DATA_ADDR, word);
        check_data("overflow drained", make_data(1'b0, 8'h00), word);
    endtask

    initial begin : main
        uart_rdata_t word;
        int i;
        seed      = 32'hc9be5f25;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        bus_addr  = '0;
        bus_we    = 1'b0;
        bus_re    = 1'b0;
        bus_wdata = '0;
        loopback  = 1'b1;
        line_rxd  = 1'b1;
        set_entry(0, "loop_a", MODE_LOOP);
        set_entry(1, "loop_b", MODE_LOOP);
        set_entry(2, "good_a", MODE_GOOD);
        set_entry(3, "bad_a", MODE_BAD);
        set_entry(4, "loop_c", MODE_LOOP);
        set_entry(5, "good_b", MODE_GOOD);
        set_entry(6, "bad_b", MODE_BAD);
        set_entry(7, "loop_d", MODE_LOOP);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle state out of reset.
        check_bit("reset bus_ready", 1'b0, bus_ready);
        check_bit("reset txd", 1'b1, txd);
        check_bit("reset tx_empty", 1'b1, tx_empty);
        check_bit("reset rx_avail", 1'b0, rx_avail);
        bus_read(STATUS_ADDR, word);
        check_status("reset status",
            make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), word);

        for (i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end
        bus_read(DATA_ADDR, word);
        check_data("empty read", make_data(1'b0, 8'h00), word);

        stall_test();
        overflow_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== uart.f ====
rtl/uart_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_periph.sv
test/uart_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := uart_tb
FILELIST   := uart.f
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log
SRCS       := $(wildcard rtl/*.sv test/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
